// File: sources.f
+incdir+include
rtl/sink_buf_pkg.sv
rtl/sram_port_if.sv
rtl/line_sram.sv
rtl/chan_ptr_table.sv
rtl/read_arbiter.sv
rtl/eos_tracker.sv
rtl/sink_buf_top.sv
tb/sink_buf_asserts.sv
tb/sink_buf_tb.sv

// File: Bender.yml
package:
  name: sink_buf

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/sink_buf_pkg.sv
      - rtl/sram_port_if.sv
      - rtl/line_sram.sv
      - rtl/chan_ptr_table.sv
      - rtl/read_arbiter.sv
      - rtl/eos_tracker.sv
      - rtl/sink_buf_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/sink_buf_asserts.sv
      - tb/sink_buf_tb.sv

// File: tb/sink_buf_tb.sv
// ====================
// Directed testbench of the sink buffer with one reference queue per channel
// Compile with sources.f and run top module sink_buf_tb
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module sink_buf_tb;

    localparam int CH         = `SB_CHANNELS;
    localparam int HW         = 2 + `SB_CHUNKS;      // Type and chunk bits above data
    localparam int LW         = HW + `SB_DATA_W;     // Reference line width
    localparam int MAX_CYCLES = 2000;                // Tests need about 250 cycles

    logic                     clk;
    logic                     rst_n;
    logic                     wr_valid;
    logic                     wr_ready;
    sink_buf_pkg::chan_t      wr_channel;
    logic [1:0]               wr_type;
    logic                     wr_eos;
    logic [`SB_CHUNKS-1:0]    wr_chunk_en;
    logic [`SB_DATA_W-1:0]    wr_data;
    logic [CH-1:0]            rd_req;
    logic                     rd_valid;
    sink_buf_pkg::chan_t      rd_channel;
    logic [1:0]               rd_type;
    logic [`SB_CHUNKS-1:0]    rd_chunk_en;
    logic [`SB_DATA_W-1:0]    rd_data;
    logic                     eos_completion_valid;
    logic                     eos_completion_ready;
    sink_buf_pkg::chan_t      eos_completion_channel;
    logic                     drain_enable;
    logic [CH-1:0]            channel_full;
    logic [CH-1:0]            backpressure_warning;
    logic [CH-1:0]            eos_pending;

    logic [LW-1:0] ref_q [CH][$];   // Accepted lines with the oldest first
    int            rd_log[$];       // Channel of every returned read
    int            eos_exp[$];      // Completions in enqueue order
    int            err_count   = 0;
    int            cycle_count = 0;

    sink_buf_top uut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .wr_valid               (wr_valid),
        .wr_ready               (wr_ready),
        .wr_channel             (wr_channel),
        .wr_type                (wr_type),
        .wr_eos                 (wr_eos),
        .wr_chunk_en            (wr_chunk_en),
        .wr_data                (wr_data),
        .rd_req                 (rd_req),
        .rd_valid               (rd_valid),
        .rd_channel             (rd_channel),
        .rd_type                (rd_type),
        .rd_chunk_en            (rd_chunk_en),
        .rd_data                (rd_data),
        .eos_completion_valid   (eos_completion_valid),
        .eos_completion_ready   (eos_completion_ready),
        .eos_completion_channel (eos_completion_channel),
        .drain_enable           (drain_enable),
        .channel_full           (channel_full),
        .backpressure_warning   (backpressure_warning),
        .eos_pending            (eos_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // Reporting
    // ====================
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            err_count++;
            abort_run();
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // Every returned line must be the oldest one of its channel
    always @(negedge clk) begin : read_monitor
        logic [LW-1:0] exp_line;
        #1;
        if (rst_n && rd_valid) begin
            if (ref_q[rd_channel].size() == 0) begin
                $display("Read on channel %0d at %0t returned a line never written",
                         rd_channel, $time);
                err_count++;
                abort_run();
            end else begin
                exp_line = ref_q[rd_channel].pop_front();
                check_eq({rd_type, rd_chunk_en, rd_data}, exp_line, "read line");
                rd_log.push_back(int'(rd_channel));
            end
        end
    end

    // ====================
    // Drivers
    // ====================
    task automatic write_line(input int ch, input logic eos, output logic accepted);
        logic [LW-1:0] word;
        word[`SB_DATA_W-1:0]  = $urandom;
        word[LW-1:`SB_DATA_W] = HW'($urandom_range(2**HW - 1, 0));
        @(negedge clk);
        wr_valid    = 1'b1;
        wr_channel  = sink_buf_pkg::chan_t'(ch);
        wr_eos      = eos;
        wr_type     = word[LW-1 -: 2];
        wr_chunk_en = word[`SB_DATA_W +: `SB_CHUNKS];
        wr_data     = word[`SB_DATA_W-1:0];
        #1;
        accepted = wr_ready;             // Taken at the coming rising edge
        if (accepted) begin
            ref_q[ch].push_back(word);
            if (eos) eos_exp.push_back(ch);
        end
    endtask

    task automatic idle_write();
        @(negedge clk);
        wr_valid = 1'b0;
        wr_eos   = 1'b0;
        #1;
    endtask

    function automatic int queued_lines();
        int n;
        n = 0;
        for (int c = 0; c < CH; c++) n += ref_q[c].size();
        return n;
    endfunction

    // Empty every queue and allow no read past the last line
    task automatic drain_all();
        @(negedge clk);
        drain_enable = 1'b1;
        rd_req       = '1;
        while (queued_lines() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
        drain_enable = 1'b0;
        rd_req       = '0;
    endtask

    // ====================
    // Tests
    // ====================
    task automatic check_reset_state();
        for (int c = 0; c < CH; c++) begin
            @(negedge clk);
            wr_channel = sink_buf_pkg::chan_t'(c);
            #1;
            check_eq(wr_ready, 1'b1, "wr_ready after reset");
        end
        check_eq(rd_valid, 1'b0, "rd_valid after reset");
        check_eq(eos_completion_valid, 1'b0, "eos_completion_valid after reset");
        check_eq(eos_pending, '0, "eos_pending after reset");
        check_eq(channel_full, '0, "channel_full after reset");
        check_eq(backpressure_warning, '0, "backpressure_warning after reset");
    endtask

    task automatic ordered_reads();
        int   cnt [CH] = '{5, 6, 0, 4};  // Lines per channel
        logic acc;
        for (int i = 0; i < 6; i++) begin
            for (int c = 0; c < CH; c++) begin
                if (i < cnt[c]) begin
                    write_line(c, 1'b0, acc);
                    check_eq(acc, 1'b1, "write accepted");
                end
            end
        end
        idle_write();
        drain_all();
    endtask

    task automatic threshold_drain();
        logic acc;
        int   n0;
        for (int i = 0; i < `SB_USED_THRESHOLD - 1; i++) begin
            write_line(2, 1'b0, acc);
        end
        idle_write();
        n0 = rd_log.size();
        rd_req[2] = 1'b1;
        repeat (6) @(negedge clk);
        check_eq(rd_log.size(), n0, "reads below threshold");
        drain_enable = 1'b1;             // Partial queue may leave now
        while (ref_q[2].size() != 0) @(negedge clk);
        check_eq(rd_log.size() - n0, `SB_USED_THRESHOLD - 1, "drained reads");
        repeat (2) @(negedge clk);
        drain_enable = 1'b0;
        rd_req       = '0;
    endtask

    task automatic margin_full();
        logic acc;
        int   taken;
        int   n0;
        taken = 0;
        acc   = 1'b1;
        while (acc && taken <= `SB_LINES) begin
            write_line(1, 1'b0, acc);
            if (acc) taken++;
        end
        check_eq(taken, `SB_LINES - `SB_OVERFLOW_MARGIN, "lines accepted before full");
        check_eq(channel_full, 4'b0010, "channel_full at margin");
        check_eq(backpressure_warning, 4'b0010, "backpressure_warning at margin");
        idle_write();
        n0 = rd_log.size();
        rd_req[1] = 1'b1;
        @(negedge clk);
        rd_req = '0;                     // One grant only
        while (rd_log.size() == n0) @(negedge clk);
        #1;
        check_eq(wr_ready, 1'b1, "wr_ready after one read");
        check_eq(channel_full[1], 1'b0, "channel_full after one read");
        drain_all();
    endtask

    task automatic fair_arbitration();
        int   total;
        int   n0;
        logic acc;
        total = CH * (`SB_USED_THRESHOLD + 1);  // Reads until each drops below threshold
        for (int i = 0; i < 2 * `SB_USED_THRESHOLD * CH; i++) begin
            write_line(i % CH, 1'b0, acc);
        end
        idle_write();
        n0     = rd_log.size();
        rd_req = '1;
        while (rd_log.size() < n0 + total) @(negedge clk);
        repeat (4) @(negedge clk);
        check_eq(rd_log.size(), n0 + total, "reads stop below threshold");
        for (int i = 1; i < total; i++) begin
            check_eq(rd_log[n0+i], (rd_log[n0+i-1] + 1) % CH, "round-robin order");
        end
        rd_req = '0;
        drain_all();
    endtask

    task automatic eos_completion();
        logic acc;
        eos_completion_ready = 1'b0;
        write_line(0, 1'b1, acc);
        idle_write();
        check_eq(eos_pending, 4'b0001, "eos_pending after first EOS");
        write_line(2, 1'b1, acc);
        idle_write();
        check_eq(eos_pending, 4'b0100, "eos_pending after second EOS");
        repeat (3) begin
            @(negedge clk);
            #1;
            check_eq(eos_pending, '0, "eos_pending cleared into FIFO");
            check_eq(eos_completion_valid, 1'b1, "completion held without ready");
            check_eq(eos_completion_channel, eos_exp[0], "held completion channel");
        end
        @(negedge clk);
        eos_completion_ready = 1'b1;
        while (eos_exp.size() != 0) begin
            #1;
            check_eq(eos_completion_valid, 1'b1, "completion valid");
            check_eq(eos_completion_channel, eos_exp.pop_front(), "completion order");
            @(negedge clk);
        end
        #1;
        check_eq(eos_completion_valid, 1'b0, "completion FIFO empty");
        eos_completion_ready = 1'b0;
        drain_all();
    endtask

    // ====================
    // Sequence
    // ====================
    initial begin
        void'($urandom(32'hac42));
        rst_n                = 1'b0;
        wr_valid             = 1'b0;
        wr_channel           = '0;
        wr_type              = '0;
        wr_eos               = 1'b0;
        wr_chunk_en          = '0;
        wr_data              = '0;
        rd_req               = '0;
        drain_enable         = 1'b0;
        eos_completion_ready = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        ordered_reads();
        threshold_drain();
        margin_full();
        fair_arbitration();
        eos_completion();
        repeat (2) @(negedge clk);

        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: tb/sink_buf_asserts.sv
// ====================
// Protocol assertions, bound into the sink buffer top
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module sink_buf_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     rd_valid,
    input logic                     wr_ready,
    input sink_buf_pkg::chan_t      wr_channel,
    input logic [`SB_CHANNELS-1:0]  channel_full,
    input logic                     eos_completion_valid,
    input logic                     eos_completion_ready,
    input sink_buf_pkg::chan_t      eos_completion_channel
);

    // No read word right out of reset
    assert property (@(posedge clk) !rst_n |=> !rd_valid)
        else $error("rd_valid high in the cycle after reset");

    // Head entry holds under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        (eos_completion_valid && !eos_completion_ready) |=>
        (eos_completion_valid && $stable(eos_completion_channel)))
        else $error("EOS completion changed while stalled");

    // Full channel refuses writes
    assert property (@(posedge clk) disable iff (!rst_n)
        channel_full[wr_channel] |-> !wr_ready)
        else $error("wr_ready high on a full channel");

endmodule

bind sink_buf_top sink_buf_asserts u_asserts (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .rd_valid               (rd_valid),
    .wr_ready               (wr_ready),
    .wr_channel             (wr_channel),
    .channel_full           (channel_full),
    .eos_completion_valid   (eos_completion_valid),
    .eos_completion_ready   (eos_completion_ready),
    .eos_completion_channel (eos_completion_channel)
);

`default_nettype wire

// File: rtl/sink_buf_top.sv
// ====================
// Multi-channel sink buffer top, line SRAM shared by all channel queues
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module sink_buf_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Write
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  sink_buf_pkg::chan_t      wr_channel,
    input  logic [1:0]               wr_type,
    input  logic                     wr_eos,         // Completion only, not stored
    input  logic [`SB_CHUNKS-1:0]    wr_chunk_en,
    input  logic [`SB_DATA_W-1:0]    wr_data,
    // Read, one shared output tagged with its channel
    input  logic [`SB_CHANNELS-1:0]  rd_req,
    output logic                     rd_valid,
    output sink_buf_pkg::chan_t      rd_channel,
    output logic [1:0]               rd_type,
    output logic [`SB_CHUNKS-1:0]    rd_chunk_en,
    output logic [`SB_DATA_W-1:0]    rd_data,
    // EOS completion
    output logic                     eos_completion_valid,
    input  logic                     eos_completion_ready,
    output sink_buf_pkg::chan_t      eos_completion_channel,
    // Control and status
    input  logic                     drain_enable,
    output logic [`SB_CHANNELS-1:0]  channel_full,
    output logic [`SB_CHANNELS-1:0]  backpressure_warning,
    output logic [`SB_CHANNELS-1:0]  eos_pending
);

    logic                    wr_accept;
    logic [`SB_CHANNELS-1:0] eligible;
    logic [`SB_CHANNELS-1:0] grant;
    logic                    grant_valid;

    sram_port_if sram_bus ();

    // ====================
    // Storage and queues
    // ====================
    line_sram u_line_sram (
        .clk  (clk),
        .port (sram_bus.mem)
    );

    chan_ptr_table u_chan_ptr_table (
        .clk                  (clk),
        .rst_n                (rst_n),
        .wr_valid             (wr_valid),
        .wr_channel           (wr_channel),
        .wr_type              (wr_type),
        .wr_chunk_en          (wr_chunk_en),
        .wr_data              (wr_data),
        .wr_ready             (wr_ready),
        .wr_accept            (wr_accept),
        .drain_enable         (drain_enable),
        .grant_valid          (grant_valid),
        .grant                (grant),
        .eligible             (eligible),
        .rd_channel           (rd_channel),
        .rd_valid             (rd_valid),
        .channel_full         (channel_full),
        .backpressure_warning (backpressure_warning),
        .sram_wr              (sram_bus.writer),
        .sram_rd              (sram_bus.reader)
    );

    // ====================
    // Arbitration and EOS
    // ====================
    read_arbiter u_read_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_req      (rd_req),
        .eligible    (eligible),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    eos_tracker u_eos_tracker (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .wr_accept              (wr_accept),
        .wr_channel             (wr_channel),
        .wr_eos                 (wr_eos),
        .eos_completion_ready   (eos_completion_ready),
        .eos_completion_valid   (eos_completion_valid),
        .eos_completion_channel (eos_completion_channel),
        .eos_pending            (eos_pending)
    );

    // Read word fields, qualified by rd_valid
    assign rd_type     = sram_bus.rd_line.line_type;
    assign rd_chunk_en = sram_bus.rd_line.chunk_en;
    assign rd_data     = sram_bus.rd_line.data;

endmodule

`default_nettype wire

// File: rtl/eos_tracker.sv
// ====================
// EOS pending bits per channel and the completion FIFO toward the scheduler
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module eos_tracker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_accept,
    input  sink_buf_pkg::chan_t      wr_channel,
    input  logic                     wr_eos,
    input  logic                     eos_completion_ready,
    output logic                     eos_completion_valid,
    output sink_buf_pkg::chan_t      eos_completion_channel,
    output logic [`SB_CHANNELS-1:0]  eos_pending
);

    localparam int FB = $clog2(`SB_EOS_FIFO_DEPTH);

    sink_buf_pkg::chan_t     fifo_mem [`SB_EOS_FIFO_DEPTH];
    logic [FB:0]             fifo_wp;    // Extra bit tells full from empty
    logic [FB:0]             fifo_rp;
    logic                    fifo_full;
    logic                    enq;
    logic                    deq;
    sink_buf_pkg::chan_t     low_chan;   // Lowest pending channel
    logic [`SB_CHANNELS-1:0] set_mask;
    logic [`SB_CHANNELS-1:0] clr_mask;

    // ====================
    // Pending bits
    // ====================
    always_comb begin
        low_chan = '0;
        for (int i = `SB_CHANNELS - 1; i >= 0; i--) begin
            if (eos_pending[i]) low_chan = sink_buf_pkg::chan_t'(i);  // Lowest wins
        end
    end

    assign enq = (|eos_pending) && !fifo_full;  // Bits wait while FIFO is full
    assign deq = eos_completion_valid && eos_completion_ready;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (wr_accept && wr_eos) set_mask[wr_channel] = 1'b1;
        if (enq)                 clr_mask[low_chan]   = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eos_pending <= '0;
            fifo_wp     <= '0;
            fifo_rp     <= '0;
        end else begin
            eos_pending <= (eos_pending & ~clr_mask) | set_mask;  // New EOS beats clear
            if (enq) fifo_wp <= fifo_wp + 1'b1;
            if (deq) fifo_rp <= fifo_rp + 1'b1;
        end
    end

    // ====================
    // Completion FIFO
    // ====================
    always_ff @(posedge clk) begin
        if (enq) fifo_mem[fifo_wp[FB-1:0]] <= low_chan;
    end

    assign fifo_full = (fifo_wp[FB] != fifo_rp[FB]) &&
                       (fifo_wp[FB-1:0] == fifo_rp[FB-1:0]);

    // Head entry holds under back-pressure
    assign eos_completion_valid   = fifo_wp != fifo_rp;
    assign eos_completion_channel = fifo_mem[fifo_rp[FB-1:0]];

endmodule

`default_nettype wire

// File: rtl/read_arbiter.sv
// ====================
// Round-robin grant of the single SRAM read port
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module read_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SB_CHANNELS-1:0]  rd_req,
    input  logic [`SB_CHANNELS-1:0]  eligible,
    output logic [`SB_CHANNELS-1:0]  grant,        // One-hot
    output logic                     grant_valid
);

    sink_buf_pkg::chan_t     prio;      // Channel checked first
    sink_buf_pkg::chan_t     gnt_idx;
    sink_buf_pkg::chan_t     idx;
    logic [`SB_CHANNELS-1:0] active;    // Requesting and eligible

    assign active = rd_req & eligible;

    // ====================
    // Search from prio upward, wrapping
    // ====================
    always_comb begin
        grant_valid = 1'b0;
        gnt_idx     = '0;
        idx         = '0;
        for (int k = 0; k < `SB_CHANNELS; k++) begin
            idx = prio + sink_buf_pkg::chan_t'(k);  // Wraps at channel count
            if (!grant_valid && active[idx]) begin
                grant_valid = 1'b1;
                gnt_idx     = idx;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (grant_valid) grant[gnt_idx] = 1'b1;
    end

    // Priority moves just past the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= '0;
        end else if (grant_valid) begin
            prio <= gnt_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/chan_ptr_table.sv
// ====================
// Per-channel queue state: pointers, counts, write gating, read eligibility
// Drives both SRAM ports and tags the returning read word with its channel
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module chan_ptr_table (
    input  logic                       clk,
    input  logic                       rst_n,
    // Write side
    input  logic                       wr_valid,
    input  sink_buf_pkg::chan_t        wr_channel,
    input  logic [1:0]                 wr_type,
    input  logic [`SB_CHUNKS-1:0]      wr_chunk_en,
    input  logic [`SB_DATA_W-1:0]      wr_data,
    output logic                       wr_ready,
    output logic                       wr_accept,     // Strobe toward EOS tracker
    // Read side
    input  logic                       drain_enable,
    input  logic                       grant_valid,
    input  logic [`SB_CHANNELS-1:0]    grant,         // One-hot from arbiter
    output logic [`SB_CHANNELS-1:0]    eligible,
    output sink_buf_pkg::chan_t        rd_channel,
    output logic                       rd_valid,
    // Status
    output logic [`SB_CHANNELS-1:0]    channel_full,
    output logic [`SB_CHANNELS-1:0]    backpressure_warning,
    // SRAM
    sram_port_if.writer                sram_wr,
    sram_port_if.reader                sram_rd
);

    localparam int LB = $clog2(`SB_LINES);  // Offset bits inside a region

    sink_buf_pkg::ptr_t   wr_ptr [`SB_CHANNELS];
    sink_buf_pkg::ptr_t   rd_ptr [`SB_CHANNELS];
    sink_buf_pkg::count_t used   [`SB_CHANNELS];
    sink_buf_pkg::count_t open   [`SB_CHANNELS];

    logic [`SB_CHANNELS-1:0] wr_hit;   // Accepted write per channel
    logic [`SB_CHANNELS-1:0] rd_hit;   // Granted read per channel
    sink_buf_pkg::chan_t     gnt_chan; // Granted channel, encoded
    sink_buf_pkg::line_t     line_in;

    // ====================
    // Write path
    // ====================
    // Only state and the addressed channel, never wr_valid
    assign wr_ready  = open[wr_channel] > sink_buf_pkg::count_t'(`SB_OVERFLOW_MARGIN);
    assign wr_accept = wr_valid && wr_ready;

    always_comb begin
        line_in.line_type = wr_type;
        line_in.chunk_en  = wr_chunk_en;
        line_in.data      = wr_data;
    end

    assign sram_wr.wr_en   = wr_accept;
    assign sram_wr.wr_addr = {wr_channel, wr_ptr[wr_channel][LB-1:0]};  // Region + offset
    assign sram_wr.wr_line = line_in;

    // ====================
    // Read path
    // ====================
    always_comb begin
        gnt_chan = '0;
        for (int i = 0; i < `SB_CHANNELS; i++) begin
            if (grant[i]) gnt_chan = sink_buf_pkg::chan_t'(i);
        end
    end

    assign sram_rd.rd_en   = grant_valid;
    assign sram_rd.rd_addr = {gnt_chan, rd_ptr[gnt_chan][LB-1:0]};

    assign rd_hit = grant_valid ? grant : '0;

    always_comb begin
        for (int i = 0; i < `SB_CHANNELS; i++) begin
            wr_hit[i]   = wr_accept && (wr_channel == sink_buf_pkg::chan_t'(i));
            // Threshold reached, or drain lets a partial queue out
            eligible[i] = (used[i] >= sink_buf_pkg::count_t'(`SB_USED_THRESHOLD)) ||
                          (drain_enable && (used[i] != '0));
            // Writes refused from here on
            channel_full[i] = open[i] <= sink_buf_pkg::count_t'(`SB_OVERFLOW_MARGIN);
            // Early warning at twice the margin
            backpressure_warning[i] =
                open[i] <= sink_buf_pkg::count_t'(2 * `SB_OVERFLOW_MARGIN);
        end
    end

    // ====================
    // Queue state
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SB_CHANNELS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                used[i]   <= '0;
                open[i]   <= sink_buf_pkg::count_t'(`SB_LINES);  // Whole region free
            end
            rd_valid <= 1'b0;
        end else begin
            for (int i = 0; i < `SB_CHANNELS; i++) begin
                if (wr_hit[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
                if (rd_hit[i]) rd_ptr[i] <= rd_ptr[i] + 1'b1;
                case ({wr_hit[i], rd_hit[i]})
                    2'b10: begin
                        used[i] <= used[i] + 1'b1;
                        open[i] <= open[i] - 1'b1;
                    end
                    2'b01: begin
                        used[i] <= used[i] - 1'b1;
                        open[i] <= open[i] + 1'b1;
                    end
                    default: ;  // Both or neither, counts unchanged
                endcase
            end
            rd_valid <= grant_valid;  // Marks the SRAM word returning next cycle
        end
    end

    // Channel tag travels alongside the SRAM read latency
    always_ff @(posedge clk) begin
        if (grant_valid) rd_channel <= gnt_chan;
    end

endmodule

`default_nettype wire

// File: rtl/line_sram.sv
// ====================
// Line SRAM, one write and one read port, every channel region in one array
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

module line_sram (
    input  logic      clk,
    sram_port_if.mem  port
);

    localparam int DEPTH = `SB_CHANNELS * `SB_LINES;

    // ====================
    // Storage
    // ====================
    sink_buf_pkg::line_t mem [DEPTH];  // No reset, contents are payload

    // Write port
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_line;
        end
    end

    // Read port, word registered so it appears after the issuing edge
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            port.rd_line <= mem[port.rd_addr];  // Holds last word when idle
        end
    end

endmodule

`default_nettype wire

// File: rtl/sram_port_if.sv
// ====================
// Write and read ports of the shared line SRAM
// ====================
`default_nettype none

interface sram_port_if;

    // Write port
    logic                  wr_en;
    sink_buf_pkg::addr_t   wr_addr;
    sink_buf_pkg::line_t   wr_line;

    // Read port, one cycle latency
    logic                  rd_en;
    sink_buf_pkg::addr_t   rd_addr;
    sink_buf_pkg::line_t   rd_line;  // Valid the cycle after rd_en

    // Pointer table side, write half
    modport writer (output wr_en, wr_addr, wr_line);

    // Pointer table side, read half
    modport reader (output rd_en, rd_addr, input rd_line);

    // Memory side
    modport mem (input wr_en, wr_addr, wr_line, rd_en, rd_addr, output rd_line);

endinterface

`default_nettype wire

// File: rtl/sink_buf_pkg.sv
// ====================
// Shared types of the sink buffer, referenced by scoped name
// ====================
`default_nettype none

`include "sink_buf_cfg.svh"

package sink_buf_pkg;

    // Channel number
    typedef logic [$clog2(`SB_CHANNELS)-1:0] chan_t;

    // Queue pointer, MSB is the wrap bit
    typedef logic [$clog2(`SB_LINES):0] ptr_t;

    // Used or open count, one extra bit so a full region fits
    typedef logic [$clog2(`SB_LINES):0] count_t;

    // SRAM address is {channel region, line offset}
    typedef logic [$clog2(`SB_CHANNELS*`SB_LINES)-1:0] addr_t;

    // Word held in the line SRAM, EOS is not stored
    typedef struct packed {
        logic [1:0]            line_type;  // Line type from the writer
        logic [`SB_CHUNKS-1:0] chunk_en;   // Valid chunks of the payload
        logic [`SB_DATA_W-1:0] data;       // Payload
    } line_t;

endpackage

`default_nettype wire

// File: include/sink_buf_cfg.svh
// ====================
// Sizes and thresholds of the multi-channel sink buffer
// Included by the package, the RTL and the testbench
// ====================
`ifndef SINK_BUF_CFG_SVH
`define SINK_BUF_CFG_SVH

// Geometry
`define SB_CHANNELS 4           // Number of channels
`define SB_LINES 16             // Lines per channel region
`define SB_DATA_W 32            // Payload bits per line
`define SB_CHUNKS 4             // Chunk enable bits per line

// Flow control
`define SB_OVERFLOW_MARGIN 2    // Open lines kept free before writes are refused
`define SB_USED_THRESHOLD 4     // Used lines needed before a read without drain

// Completion queue
`define SB_EOS_FIFO_DEPTH 4     // Entries in the EOS completion FIFO

`endif
